/* all.f */
+incdir+src
src/neuron_pkg.sv
src/neuron_mac.sv
src/sum_fifo.sv
src/logsig_unit.sv
src/neuron_layer.sv
tests/tb_clock.sv
tests/neuron_layer_asserts.sv
tests/neuron_layer_tb.sv

/* src/logsig_unit.sv */
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module logsig_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      hold,
    input  logic                      empty,
    input  neuron_pkg::sum_item_t     head,
    output logic                      pop,
    output logic                      act_valid,
    output logic [`NEURON_TAG_W-1:0]  act_tag,
    output logic [`NEURON_ACT_W-1:0]  activation
);

    localparam int SUM_W     = `NEURON_SUM_W;
    localparam int ACT_W     = `NEURON_ACT_W;
    localparam int TAG_W     = `NEURON_TAG_W;
    localparam int SUM_FRAC  = `NEURON_INPUT_FRAC + `NEURON_WEIGHT_FRAC;
    // bring the magnitude to units of 1/256
    localparam int MAG_SHIFT = SUM_FRAC - 8;

    // segment ends, 1.0 2.375 5.0
    localparam logic [SUM_W-1:0] SEG1_END = SUM_W'(256);
    localparam logic [SUM_W-1:0] SEG2_END = SUM_W'(608);
    localparam logic [SUM_W-1:0] SEG3_END = SUM_W'(1280);

    // slopes as shifts, offsets in 1/256
    localparam int         SEG1_SHIFT = 2;
    localparam int         SEG2_SHIFT = 3;
    localparam int         SEG3_SHIFT = 5;
    localparam logic [8:0] SEG1_OFF   = 9'd128;
    localparam logic [8:0] SEG2_OFF   = 9'd160;
    localparam logic [8:0] SEG3_OFF   = 9'd216;
    localparam logic [8:0] P_ONE      = 9'd256;
    localparam logic [8:0] ACT_MAX    = 9'((1 << ACT_W) - 1);

    logic              advance;
    logic [SUM_W-1:0]  sum_abs;

    logic              s1_valid;
    logic [TAG_W-1:0]  s1_tag;
    logic              s1_neg;
    logic [SUM_W-1:0]  s1_mag;

    logic [8:0]        p;
    logic [8:0]        act_full;
    logic              s2_valid;

    // hold freezes both stages together
    assign advance = !hold;
    assign pop     = advance && !empty;

    ////////////////////
    // stage 1
    ////////////////////

    // magnitude of the two's complement sum
    assign sum_abs = head.sum[SUM_W-1] ? SUM_W'(-head.sum) : SUM_W'(head.sum);

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s1_tag <= head.tag;
            s1_neg <= head.sum[SUM_W-1];
            s1_mag <= sum_abs >> MAG_SHIFT;
        end
    end

    ////////////////////
    // stage 2
    ////////////////////

    // piecewise linear upper half of the logistic curve
    always_comb begin
        if (s1_mag < SEG1_END) begin
            p = 9'(s1_mag >> SEG1_SHIFT) + SEG1_OFF;
        end else if (s1_mag < SEG2_END) begin
            p = 9'(s1_mag >> SEG2_SHIFT) + SEG2_OFF;
        end else if (s1_mag < SEG3_END) begin
            p = 9'(s1_mag >> SEG3_SHIFT) + SEG3_OFF;
        end else begin
            p = P_ONE;
        end
    end

    // negative side by symmetry, positive side saturates
    assign act_full = s1_neg ? (P_ONE - p) : ((p > ACT_MAX) ? ACT_MAX : p);

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else if (advance) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            act_tag    <= s1_tag;
            activation <= ACT_W'(act_full);
        end
    end

    // frozen result shows once hold drops
    assign act_valid = s2_valid && !hold;

endmodule

/* src/neuron_cfg.svh */
`ifndef NEURON_CFG_SVH
`define NEURON_CFG_SVH

// connections per neuron
`define NEURON_MAX_INPUTS 8

// signed inputs, q3.4
`define NEURON_INPUT_W 8
`define NEURON_INPUT_FRAC 4

// signed weights, q3.4
`define NEURON_WEIGHT_W 8
`define NEURON_WEIGHT_FRAC 4

// accumulator with 8 fraction bits
// room for eight full scale products
`define NEURON_SUM_W 20

// unsigned activation, logistic output scaled by 256
`define NEURON_ACT_W 8

// request bookkeeping
`define NEURON_TAG_W 4
`define NEURON_COUNT_W 4

// finished sums waiting for the logistic stage
`define SUM_FIFO_DEPTH 4

`endif

/* src/neuron_layer.sv */
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module neuron_layer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  neuron_pkg::neuron_req_t   req,
    input  logic                      hold,
    output logic                      busy,
    output logic                      act_valid,
    output logic [`NEURON_TAG_W-1:0]  act_tag,
    output logic [`NEURON_ACT_W-1:0]  activation
);

    ////////////////////
    // internal links
    ////////////////////

    // mac to fifo
    logic                  push;
    neuron_pkg::sum_item_t push_item;
    logic                  full;

    // fifo to logistic stage
    logic                  pop;
    neuron_pkg::sum_item_t head;
    logic                  empty;

    ////////////////////
    // producer
    ////////////////////

    neuron_mac mac0 (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .req       (req),
        .full      (full),
        .busy      (busy),
        .push      (push),
        .push_item (push_item)
    );

    ////////////////////
    // buffer
    ////////////////////

    sum_fifo fifo0 (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    ////////////////////
    // consumer
    ////////////////////

    logsig_unit logsig0 (
        .clk        (clk),
        .rst        (rst),
        .hold       (hold),
        .empty      (empty),
        .head       (head),
        .pop        (pop),
        .act_valid  (act_valid),
        .act_tag    (act_tag),
        .activation (activation)
    );

endmodule

/* src/neuron_mac.sv */
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module neuron_mac (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  neuron_pkg::neuron_req_t  req,
    input  logic                     full,
    output logic                     busy,
    output logic                     push,
    output neuron_pkg::sum_item_t    push_item
);

    localparam int SUM_W   = `NEURON_SUM_W;
    localparam int PROD_W  = `NEURON_INPUT_W + `NEURON_WEIGHT_W;
    localparam int COUNT_W = `NEURON_COUNT_W;
    localparam int MAX_IN  = `NEURON_MAX_INPUTS;

    neuron_pkg::mac_state_e   state;
    neuron_pkg::neuron_req_t  req_q;

    // index of the connection being multiplied
    logic [COUNT_W-1:0]       idx;
    logic [COUNT_W-1:0]       last_idx;

    logic signed [SUM_W-1:0]  acc;
    logic signed [PROD_W-1:0] product;
    logic signed [SUM_W-1:0]  term;

    logic                     accept;

    ////////////////////
    // request latch
    ////////////////////

    // start only counts in idle
    assign accept = (state == neuron_pkg::MAC_IDLE) && start;

    // inputs and weights stay stable for the whole walk
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // counts above the connection limit walk all connections
    assign last_idx = (req_q.count > COUNT_W'(MAX_IN)) ? COUNT_W'(MAX_IN - 1)
                                                       : req_q.count - 1'b1;

    ////////////////////
    // datapath
    ////////////////////

    // q3.4 times q3.4 gives 8 fraction bits
    assign product = $signed(req_q.inputs[idx]) * $signed(req_q.weights[idx]);

    // sign extend up to accumulator width
    assign term = SUM_W'(product);

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= neuron_pkg::MAC_IDLE;
            idx   <= '0;
            acc   <= '0;
        end else begin
            case (state)
                neuron_pkg::MAC_IDLE: begin
                    if (start) begin
                        idx <= '0;
                        acc <= '0;
                        // nothing to add, straight to delivery
                        if (req.count == '0) begin
                            state <= neuron_pkg::MAC_DELIVER;
                        end else begin
                            state <= neuron_pkg::MAC_ACCUM;
                        end
                    end
                end
                neuron_pkg::MAC_ACCUM: begin
                    // one term per clock
                    acc <= acc + term;
                    idx <= idx + 1'b1;
                    if (idx == last_idx) begin
                        state <= neuron_pkg::MAC_DELIVER;
                    end
                end
                neuron_pkg::MAC_DELIVER: begin
                    // wait here while the fifo is full
                    if (!full) begin
                        acc   <= '0;
                        state <= neuron_pkg::MAC_IDLE;
                    end
                end
                default: begin
                    state <= neuron_pkg::MAC_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // outputs
    ////////////////////

    assign busy = (state != neuron_pkg::MAC_IDLE);

    // push never fires into a full fifo
    assign push = (state == neuron_pkg::MAC_DELIVER) && !full;

    always_comb begin
        push_item     = '0;
        push_item.tag = req_q.tag;
        push_item.sum = acc;
    end

endmodule

/* src/neuron_pkg.sv */
`include "neuron_cfg.svh"

package neuron_pkg;

    ////////////////////
    // mac control
    ////////////////////

    // serial dot product walk
    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_ACCUM,
        MAC_DELIVER
    } mac_state_e;

    ////////////////////
    // payloads
    ////////////////////

    // one request as seen at the top level
    // entry 0 of each vector is connection 0
    typedef struct packed {
        logic [`NEURON_TAG_W-1:0]                               tag;
        logic [`NEURON_COUNT_W-1:0]                             count;
        logic [`NEURON_MAX_INPUTS-1:0][`NEURON_WEIGHT_W-1:0]    weights;
        logic [`NEURON_MAX_INPUTS-1:0][`NEURON_INPUT_W-1:0]     inputs;
    } neuron_req_t;

    // finished sum, mac to fifo to logistic stage
    typedef struct packed {
        logic [`NEURON_TAG_W-1:0]         tag;
        logic signed [`NEURON_SUM_W-1:0]  sum;
    } sum_item_t;

endpackage

/* src/sum_fifo.sv */
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module sum_fifo (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  neuron_pkg::sum_item_t  push_item,
    input  logic                   pop,
    output neuron_pkg::sum_item_t  head,
    output logic                   full,
    output logic                   empty
);

    localparam int DEPTH = `SUM_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    neuron_pkg::sum_item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // qualify against the levels
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // oldest entry, valid whenever not empty
    assign head = mem[rd_ptr];

    ////////////////////
    // pointers and fill
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

endmodule

/* tests/neuron_layer_asserts.sv */
`timescale 1ns/1ps

module neuron_layer_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic hold,
    input logic busy,
    input logic act_valid,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty
);

    // failures seen so far, read by the testbench at the end
    int err_count = 0;

    ////////////////////
    // output side
    ////////////////////

    // a frozen result waits for hold to drop
    a_no_valid_in_hold: assert property (@(posedge clk) disable iff (rst)
        hold |-> !act_valid)
        else begin
            err_count++;
            $error("act_valid high while hold is high");
        end

    ////////////////////
    // fifo links
    ////////////////////

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else begin
            err_count++;
            $error("push into a full sum fifo");
        end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty)
        else begin
            err_count++;
            $error("pop from an empty sum fifo");
        end

    ////////////////////
    // request side
    ////////////////////

    // busy low means the mac sits in idle
    a_busy_after_start: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> busy)
        else begin
            err_count++;
            $error("busy did not rise after an accepted start");
        end

    // first cycle out of reset
    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!busy && !act_valid && !push && !pop))
        else begin
            err_count++;
            $error("control outputs active in the first cycle after reset");
        end

endmodule

bind neuron_layer neuron_layer_asserts asserts0 (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .hold      (hold),
    .busy      (busy),
    .act_valid (act_valid),
    .push      (push),
    .full      (full),
    .pop       (pop),
    .empty     (empty)
);

/* tests/neuron_layer_tb.sv */
`timescale 1ns/1ps
`include "neuron_cfg.svh"

module neuron_layer_tb;

    localparam int WAIT_LIMIT = 300;
    localparam int MAX_IN     = `NEURON_MAX_INPUTS;

    // one expected result
    typedef struct packed {
        logic [`NEURON_TAG_W-1:0] tag;
        logic [`NEURON_ACT_W-1:0] act;
    } expect_t;

    logic                      clk;
    logic                      rst;
    logic                      start;
    neuron_pkg::neuron_req_t   req;
    logic                      hold;
    logic                      busy;
    logic                      act_valid;
    logic [`NEURON_TAG_W-1:0]  act_tag;
    logic [`NEURON_ACT_W-1:0]  activation;

    expect_t                   exp_q[$];
    expect_t                   got_exp;
    string                     test_name;
    logic [31:0]               rng;
    logic [`NEURON_TAG_W-1:0]  next_tag;

    tb_clock clk_gen (.clk(clk));

    neuron_layer dut0 (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .req        (req),
        .hold       (hold),
        .busy       (busy),
        .act_valid  (act_valid),
        .act_tag    (act_tag),
        .activation (activation)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // dot product in 1/256 units, then the piecewise logistic rule
    function automatic logic [7:0] expected_activation(input neuron_pkg::neuron_req_t r);
        int n;
        int i;
        int x;
        int y;
        int sum;
        int a;
        int p;
        n = (r.count > MAX_IN) ? MAX_IN : r.count;
        sum = 0;
        for (i = 0; i < n; i++) begin
            x = $signed(r.inputs[i]);
            y = $signed(r.weights[i]);
            sum += x * y;
        end
        a = (sum < 0) ? -sum : sum;
        if (a < 256) p = a / 4 + 128;
        else if (a < 608) p = a / 8 + 160;
        else if (a < 1280) p = a / 32 + 216;
        else p = 256;
        if (sum < 0) return 8'(256 - p);
        return (p > 255) ? 8'd255 : 8'(p);
    endfunction

    task automatic build_random(input int cnt, output neuron_pkg::neuron_req_t r);
        int i;
        r = '0;
        r.tag = next_tag;
        r.count = cnt[`NEURON_COUNT_W-1:0];
        next_tag = next_tag + 1'b1;
        for (i = 0; i < MAX_IN; i++) begin
            rng = lcg_step(rng);
            r.inputs[i] = rng[23:16];
            r.weights[i] = rng[31:24];
        end
    endtask

    // two connections, the rest zero
    task automatic build_pair(input int in0, input int w0, input int in1, input int w1,
                              output neuron_pkg::neuron_req_t r);
        r = '0;
        r.tag = next_tag;
        r.count = 2;
        next_tag = next_tag + 1'b1;
        r.inputs[0] = in0[7:0];
        r.weights[0] = w0[7:0];
        r.inputs[1] = in1[7:0];
        r.weights[1] = w1[7:0];
    endtask

    // one start pulse, the expectation queued only if it should be taken
    task automatic send_request(input neuron_pkg::neuron_req_t r, input logic accepted);
        if (accepted) begin
            exp_q.push_back('{tag: r.tag, act: expected_activation(r)});
        end
        start <= 1'b1;
        req <= r;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (busy && n < WAIT_LIMIT);
        if (busy) stop_with_failure("timeout: busy never went low");
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) stop_with_failure("timeout: results still outstanding");
    endtask

    ////////////////////
    // scoreboard
    ////////////////////

    always @(posedge clk) begin
        if (!rst && act_valid) begin
            assert (exp_q.size() != 0)
                else stop_with_failure("result appeared with no request outstanding");
            if (exp_q.size() != 0) begin
                got_exp = exp_q.pop_front();
                assert (act_tag == got_exp.tag && activation == got_exp.act)
                    else stop_with_failure($sformatf(
                        "mismatch in %s: expected tag %0d act %0d, actual tag %0d act %0d",
                        test_name, got_exp.tag, got_exp.act, act_tag, activation));
            end
        end
    end

    // protocol checker failures stop the run as they happen
    always @(posedge clk) begin
        if (dut0.asserts0.err_count != 0) begin
            stop_with_failure("a protocol assertion on the DUT failed");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        neuron_pkg::neuron_req_t r;
        int n;
        int k;
        rst = 1'b1;
        start = 1'b0;
        hold = 1'b0;
        req = '0;
        rng = 32'h50fa_8a1f;
        next_tag = '0;
        test_name = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // quiet until the first start
        repeat (6) begin
            @(posedge clk);
            assert (!busy && !act_valid)
                else stop_with_failure("busy or act_valid high before any request");
        end

        // mac count+1, fifo one, two logistic stages
        test_name = "single_latency";
        build_random(8, r);
        send_request(r, 1'b1);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!act_valid && n < WAIT_LIMIT);
        if (!act_valid) stop_with_failure("timeout: no result for a single request");
        assert (n == 8 + 4)
            else stop_with_failure($sformatf("mismatch in %s: expected %0d, actual %0d",
                                             test_name, 8 + 4, n));
        wait_drained();

        test_name = "zero_count";
        build_random(0, r);
        send_request(r, 1'b1);
        wait_idle();
        wait_drained();

        // saturation both ways
        test_name = "extremes";
        build_random(8, r);
        r.inputs = {MAX_IN{8'sd127}};
        r.weights = {MAX_IN{8'sd127}};
        send_request(r, 1'b1);
        wait_idle();
        build_random(8, r);
        r.inputs = {MAX_IN{8'sd127}};
        r.weights = {MAX_IN{-8'sd128}};
        send_request(r, 1'b1);
        wait_drained();

        // magnitudes 255 256 607 608 1279 1280, some negative
        test_name = "segment_edges";
        build_pair(15, 17, 0, 0, r);
        send_request(r, 1'b1);
        wait_idle();
        build_pair(16, 16, 0, 0, r);
        send_request(r, 1'b1);
        wait_idle();
        build_pair(20, 30, 1, 7, r);
        send_request(r, 1'b1);
        wait_idle();
        build_pair(-16, 38, 0, 0, r);
        send_request(r, 1'b1);
        wait_idle();
        build_pair(30, -40, -1, 79, r);
        send_request(r, 1'b1);
        wait_idle();
        build_pair(32, 40, 0, 0, r);
        send_request(r, 1'b1);
        wait_idle();
        build_pair(-15, 17, 0, 0, r);
        send_request(r, 1'b1);
        wait_drained();

        // random counts, back to back
        test_name = "random_counts";
        for (k = 0; k < 12; k++) begin
            rng = lcg_step(rng);
            build_random(rng[31:16] % 9, r);
            send_request(r, 1'b1);
            wait_idle();
        end
        wait_drained();

        // fifo of four plus one parked in deliver
        test_name = "hold_backlog";
        hold <= 1'b1;
        for (k = 0; k < 5; k++) begin
            wait_idle();
            build_random(8, r);
            send_request(r, 1'b1);
        end
        repeat (20) begin
            @(posedge clk);
            assert (busy && !act_valid)
                else stop_with_failure("busy dropped or a result leaked while hold was high");
        end
        hold <= 1'b0;
        @(posedge clk);
        // short freeze with items in flight
        hold <= 1'b1;
        repeat (3) @(posedge clk);
        hold <= 1'b0;
        wait_idle();
        build_random(8, r);
        send_request(r, 1'b1);
        wait_drained();

        // second start lands in accumulate
        test_name = "start_while_busy";
        build_random(8, r);
        send_request(r, 1'b1);
        build_random(3, r);
        send_request(r, 1'b0);
        wait_idle();
        wait_drained();
        repeat (8) @(posedge clk);

        if (exp_q.size() == 0 && dut0.asserts0.err_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure("assertion errors or unmatched results at end of run");
        end
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    // free running, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule
